/* hw/gpif_defs.svh */
// GPIF bridge sizing constants
`ifndef GPIF_DEFS_SVH
`define GPIF_DEFS_SVH

////////////////////////////////////////
// Host port
////////////////////////////////////////

// Host word width in bits
`define GPIF_WORD_W 16

// Words per host frame must be even and at least 4
`define GPIF_FRAME_WORDS 8

////////////////////////////////////////
// Control block
////////////////////////////////////////

`define GPIF_NUM_REGS 16

`endif

/* hw/gpif_pkg.sv */
// GPIF bridge types
`default_nettype none
`include "gpif_defs.svh"

package gpif_pkg;

   ////////////////////////////////////////
   // Stream lines
   ////////////////////////////////////////

   // One tagged host word
   typedef struct packed {
      logic                    sof;
      logic                    eof;
      logic                    occ;
      logic [`GPIF_WORD_W-1:0] data;
   } line19_t;

   // One transmit line, first word in the low half
   // occ of 0 means both halves hold data
   typedef struct packed {
      logic                      sof;
      logic                      eof;
      logic [1:0]                occ;
      logic [2*`GPIF_WORD_W-1:0] data;
   } line36_t;

   ////////////////////////////////////////
   // Control header
   ////////////////////////////////////////

   localparam int REG_IDX_W = $clog2(`GPIF_NUM_REGS);

   // Command view of the first control word
   typedef struct packed {
      logic                              wr;
      logic [2:0]                        seq;
      logic [`GPIF_WORD_W-5-REG_IDX_W:0] rsvd;
      logic [REG_IDX_W-1:0]              idx;
   } ctrl_hdr_t;

   typedef union packed {
      logic [`GPIF_WORD_W-1:0] raw;
      ctrl_hdr_t               hdr;
   } ctrl_word_u;

endpackage

`default_nettype wire

/* hw/gpif_wr.sv */
// Host write port
`default_nettype none
`include "gpif_defs.svh"

module gpif_wr
   import gpif_pkg::*;
   (
   input  wire                     gpif_clk_i,
   input  wire                     arst_n_i,
   input  wire [`GPIF_WORD_W-1:0]  gpif_d_i,
   input  wire                     gpif_wr_i,
   input  wire                     gpif_ep_i,
   output line19_t                 data_word_o,
   output logic                    data_valid_o,
   output line19_t                 ctrl_word_o,
   output logic                    ctrl_valid_o
   );

   localparam int CNT_W = $clog2(`GPIF_FRAME_WORDS);
   localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`GPIF_FRAME_WORDS - 1);

   // Word position within the current frame, one per endpoint
   logic [CNT_W-1:0] data_cnt;
   logic [CNT_W-1:0] ctrl_cnt;
   logic             wr_data;
   logic             wr_ctrl;

   assign wr_data = gpif_wr_i & ~gpif_ep_i;
   assign wr_ctrl = gpif_wr_i & gpif_ep_i;

   ////////////////////////////////////////
   // Frame counters and strobes
   ////////////////////////////////////////

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         data_cnt     <= '0;
         ctrl_cnt     <= '0;
         data_valid_o <= 1'b0;
         ctrl_valid_o <= 1'b0;
      end else begin
         data_valid_o <= wr_data;
         ctrl_valid_o <= wr_ctrl;
         if (wr_data) begin
            data_cnt <= (data_cnt == LAST_WORD) ? '0 : data_cnt + 1'b1;
         end
         if (wr_ctrl) begin
            ctrl_cnt <= (ctrl_cnt == LAST_WORD) ? '0 : ctrl_cnt + 1'b1;
         end
      end
   end

   ////////////////////////////////////////
   // Tagged words
   ////////////////////////////////////////

   always_ff @(posedge gpif_clk_i) begin
      if (wr_data) begin
         data_word_o.sof  <= (data_cnt == '0);
         data_word_o.eof  <= (data_cnt == LAST_WORD);
         // Host words are always full
         data_word_o.occ  <= 1'b0;
         data_word_o.data <= gpif_d_i;
      end
      if (wr_ctrl) begin
         ctrl_word_o.sof  <= (ctrl_cnt == '0);
         ctrl_word_o.eof  <= (ctrl_cnt == LAST_WORD);
         ctrl_word_o.occ  <= 1'b0;
         ctrl_word_o.data <= gpif_d_i;
      end
   end

endmodule

`default_nettype wire

/* hw/line_packer.sv */
// Word pair to line packer
`default_nettype none

module line_packer
   import gpif_pkg::*;
   (
   input  wire          gpif_clk_i,
   input  wire          arst_n_i,
   input  wire line19_t word_i,
   input  wire          valid_i,
   output line36_t      line_o,
   output logic         valid_o
   );

   // High while the low half of a line is held
   logic                          half;
   logic                          first;
   logic                          hold_sof;
   logic [$bits(word_i.data)-1:0] hold_data;

   // A start of frame always opens a new pair
   assign first = ~half | word_i.sof;

   ////////////////////////////////////////
   // Pair tracking
   ////////////////////////////////////////

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         half    <= 1'b0;
         valid_o <= 1'b0;
      end else begin
         valid_o <= valid_i & ~first;
         if (valid_i) begin
            half <= first;
         end
      end
   end

   ////////////////////////////////////////
   // Line assembly
   ////////////////////////////////////////

   always_ff @(posedge gpif_clk_i) begin
      if (valid_i) begin
         if (first) begin
            hold_sof  <= word_i.sof;
            hold_data <= word_i.data;
         end else begin
            line_o.sof  <= hold_sof;
            line_o.eof  <= word_i.eof;
            // Odd byte count in the upper word leaves three bytes
            line_o.occ  <= word_i.occ ? 2'd3 : 2'd0;
            // Little endian, first word in the low half
            line_o.data <= {word_i.data, hold_data};
         end
      end
   end

endmodule

`default_nettype wire

/* hw/ctrl_regs.sv */
// Control register file
`default_nettype none
`include "gpif_defs.svh"

module ctrl_regs
   import gpif_pkg::*;
   (
   input  wire                     gpif_clk_i,
   input  wire                     arst_n_i,
   input  wire line19_t            word_i,
   input  wire                     valid_i,
   output logic [`GPIF_WORD_W-1:0] resp_o,
   output logic                    resp_valid_o
   );

   localparam int CNT_W = $clog2(`GPIF_FRAME_WORDS);
   localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`GPIF_FRAME_WORDS - 1);

   logic [`GPIF_WORD_W-1:0] regs [`GPIF_NUM_REGS];
   ctrl_word_u              cmd_word;
   logic [`GPIF_WORD_W-1:0] cmd_val;
   logic                    hdr_seen;
   logic                    cmd_done;
   logic                    seq_busy;
   logic [CNT_W-1:0]        seq_cnt;
   logic [`GPIF_WORD_W-1:0] cur_val;
   logic                    pend_vld;
   logic [`GPIF_WORD_W-1:0] pend_hdr;
   logic [`GPIF_WORD_W-1:0] pend_val;
   logic                    start;
   logic [`GPIF_WORD_W-1:0] start_hdr;
   logic [`GPIF_WORD_W-1:0] start_val;

   assign cmd_done  = valid_i & word_i.eof;
   // Pending command goes first, a fresh one can start only when idle
   assign start     = ~seq_busy & (pend_vld | cmd_done);
   assign start_hdr = pend_vld ? pend_hdr : cmd_word.raw;
   assign start_val = pend_vld ? pend_val : cmd_val;

   ////////////////////////////////////////
   // Command decode and register access
   ////////////////////////////////////////

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         hdr_seen <= 1'b0;
         for (int i = 0; i < `GPIF_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (valid_i) begin
         hdr_seen <= word_i.sof;
         if (hdr_seen && !word_i.sof && cmd_word.hdr.wr) begin
            regs[cmd_word.hdr.idx] <= word_i.data;
         end
      end
   end

   // Header on word 0, result on word 1
   always_ff @(posedge gpif_clk_i) begin
      if (valid_i && word_i.sof) begin
         cmd_word.raw <= word_i.data;
      end
      if (valid_i && hdr_seen && !word_i.sof) begin
         cmd_val <= cmd_word.hdr.wr ? word_i.data : regs[cmd_word.hdr.idx];
      end
   end

   ////////////////////////////////////////
   // Response sequencer
   ////////////////////////////////////////

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         seq_busy     <= 1'b0;
         seq_cnt      <= '0;
         pend_vld     <= 1'b0;
         resp_valid_o <= 1'b0;
      end else begin
         resp_valid_o <= start | seq_busy;
         if (start) begin
            seq_busy <= 1'b1;
            seq_cnt  <= CNT_W'(1);
         end else if (seq_busy) begin
            if (seq_cnt == LAST_WORD) begin
               seq_busy <= 1'b0;
            end
            seq_cnt <= seq_cnt + 1'b1;
         end
         // Park a command that cannot start right away
         if (cmd_done && (seq_busy || pend_vld)) begin
            pend_vld <= 1'b1;
         end else if (start && pend_vld) begin
            pend_vld <= 1'b0;
         end
      end
   end

   // Echoed header, then value, then zero padding
   always_ff @(posedge gpif_clk_i) begin
      if (start) begin
         resp_o  <= start_hdr;
         cur_val <= start_val;
      end else if (seq_cnt == CNT_W'(1)) begin
         resp_o <= cur_val;
      end else begin
         resp_o <= '0;
      end
      if (cmd_done && (seq_busy || pend_vld)) begin
         pend_hdr <= cmd_word.raw;
         pend_val <= cmd_val;
      end
   end

endmodule

`default_nettype wire

/* hw/gpif_rd.sv */
// Host response read port
`default_nettype none
`include "gpif_defs.svh"

module gpif_rd (
   input  wire                     gpif_clk_i,
   input  wire                     arst_n_i,
   input  wire [`GPIF_WORD_W-1:0]  resp_i,
   input  wire                     resp_valid_i,
   input  wire                     gpif_rd_i,
   output logic [`GPIF_WORD_W-1:0] gpif_d_o,
   output logic                    gpif_ce_o,
   output logic                    overrun_o
   );

   localparam int DEPTH = 16;
   localparam int PTR_W = $clog2(DEPTH);

   logic [`GPIF_WORD_W-1:0] buf_mem [DEPTH];
   logic [PTR_W-1:0]        wr_ptr;
   logic [PTR_W-1:0]        rd_ptr;
   logic [PTR_W:0]          count;
   logic                    full;
   logic                    push;
   logic                    pop;

   assign full      = (count == (PTR_W+1)'(DEPTH));
   assign gpif_ce_o = (count == '0);
   assign push      = resp_valid_i & ~full;
   // Reads while empty have no effect
   assign pop       = gpif_rd_i & ~gpif_ce_o;

   // Head word is always on the bus
   assign gpif_d_o = buf_mem[rd_ptr];

   ////////////////////////////////////////
   // Pointers, level and overrun
   ////////////////////////////////////////

   always_ff @(posedge gpif_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         overrun_o <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
         // Sticky until reset
         if (resp_valid_i && full) begin
            overrun_o <= 1'b1;
         end
      end
   end

   always_ff @(posedge gpif_clk_i) begin
      if (push) begin
         buf_mem[wr_ptr] <= resp_i;
      end
   end

endmodule

`default_nettype wire

/* hw/gpif_bridge.sv */
// GPIF host port bridge
`default_nettype none
`include "gpif_defs.svh"

module gpif_bridge
   import gpif_pkg::*;
   (
   input  wire                     gpif_clk_i,
   input  wire                     arst_n_i,
   input  wire [`GPIF_WORD_W-1:0]  gpif_d_i,
   input  wire                     gpif_wr_i,
   input  wire                     gpif_rd_i,
   input  wire                     gpif_ep_i,
   output logic [`GPIF_WORD_W-1:0] gpif_d_o,
   output logic                    gpif_ce_o,
   output line36_t                 tx_line_o,
   output logic                    tx_valid_o,
   output logic                    resp_overrun_o
   );

   line19_t                 data_word;
   logic                    data_valid;
   line19_t                 ctrl_word;
   logic                    ctrl_valid;
   logic [`GPIF_WORD_W-1:0] resp_word;
   logic                    resp_valid;

   ////////////////////////////////////////
   // Write side, split by endpoint
   ////////////////////////////////////////

   gpif_wr gpif_wr_inst (
      .gpif_clk_i   (gpif_clk_i),
      .arst_n_i     (arst_n_i),
      .gpif_d_i     (gpif_d_i),
      .gpif_wr_i    (gpif_wr_i),
      .gpif_ep_i    (gpif_ep_i),
      .data_word_o  (data_word),
      .data_valid_o (data_valid),
      .ctrl_word_o  (ctrl_word),
      .ctrl_valid_o (ctrl_valid)
   );

   // Transmit stream
   line_packer line_packer_inst (
      .gpif_clk_i (gpif_clk_i),
      .arst_n_i   (arst_n_i),
      .word_i     (data_word),
      .valid_i    (data_valid),
      .line_o     (tx_line_o),
      .valid_o    (tx_valid_o)
   );

   ////////////////////////////////////////
   // Control path and response readback
   ////////////////////////////////////////

   ctrl_regs ctrl_regs_inst (
      .gpif_clk_i   (gpif_clk_i),
      .arst_n_i     (arst_n_i),
      .word_i       (ctrl_word),
      .valid_i      (ctrl_valid),
      .resp_o       (resp_word),
      .resp_valid_o (resp_valid)
   );

   gpif_rd gpif_rd_inst (
      .gpif_clk_i   (gpif_clk_i),
      .arst_n_i     (arst_n_i),
      .resp_i       (resp_word),
      .resp_valid_i (resp_valid),
      .gpif_rd_i    (gpif_rd_i),
      .gpif_d_o     (gpif_d_o),
      .gpif_ce_o    (gpif_ce_o),
      .overrun_o    (resp_overrun_o)
   );

endmodule

`default_nettype wire

/* sim/gpif_bridge_properties.sv */
// GPIF bridge port assertions
`default_nettype none
`include "gpif_defs.svh"

module gpif_bridge_properties
   import gpif_pkg::*;
   (
   input wire                    clk_i,
   input wire                    arst_n_i,
   input wire [`GPIF_WORD_W-1:0] rd_data_i,
   input wire                    ce_i,
   input wire line36_t           tx_line_i,
   input wire                    tx_valid_i,
   input wire                    overrun_i
   );

   // Number of failed assertions so far
   int fail_count = 0;

   // Outputs held in their idle state while reset is low
   reset_idle_a : assert property (@(posedge clk_i) !arst_n_i |-> !tx_valid_i && ce_i)
      else begin
         $error("Transmit strobe or empty flag active during reset");
         fail_count++;
      end

   // Frames are longer than one line
   sof_eof_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tx_valid_i |-> !(tx_line_i.sof && tx_line_i.eof))
      else begin
         $error("Transmit line carries both sof and eof");
         fail_count++;
      end

   rd_data_known_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !ce_i |-> !$isunknown(rd_data_i))
      else begin
         $error("Read data unknown while the response buffer holds words");
         fail_count++;
      end

   // Sticky flag
   overrun_sticky_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
      overrun_i |=> overrun_i)
      else begin
         $error("Response overrun flag fell outside reset");
         fail_count++;
      end

endmodule

bind gpif_bridge gpif_bridge_properties gpif_bridge_properties_inst (
   .clk_i      (gpif_clk_i),
   .arst_n_i   (arst_n_i),
   .rd_data_i  (gpif_d_o),
   .ce_i       (gpif_ce_o),
   .tx_line_i  (tx_line_o),
   .tx_valid_i (tx_valid_o),
   .overrun_i  (resp_overrun_o)
);

`default_nettype wire

/* sim/gpif_bridge_tb.sv */
// GPIF bridge testbench
`default_nettype none
`include "gpif_defs.svh"

module gpif_bridge_tb
   import gpif_pkg::*;
   ();

   localparam int CLK_PERIOD      = 8;
   localparam int HALF_FRAME      = `GPIF_FRAME_WORDS / 2;
   localparam int WAIT_CYCLES     = 4 * `GPIF_FRAME_WORDS;
   localparam int NUM_FRAMES      = 16;
   localparam int WATCHDOG_CYCLES = NUM_FRAMES * `GPIF_FRAME_WORDS * 4 + 200;

   logic                    clk = 1'b0;
   logic                    arst_n;
   logic [`GPIF_WORD_W-1:0] gpif_d;
   logic                    gpif_wr;
   logic                    gpif_rd;
   logic                    gpif_ep;
   logic [`GPIF_WORD_W-1:0] gpif_q;
   logic                    gpif_ce;
   line36_t                 tx_line;
   logic                    tx_valid;
   logic                    resp_overrun;

   int                      cyc = 0;
   int                      last_wr_edge;
   logic [`GPIF_WORD_W-1:0] frame_buf [`GPIF_FRAME_WORDS];
   logic [`GPIF_WORD_W-1:0] exp_regs [`GPIF_NUM_REGS];
   logic [`GPIF_WORD_W-1:0] resp_hdr_q [$];
   logic [`GPIF_WORD_W-1:0] resp_val_q [$];
   line36_t                 tx_q [$];
   int                      tx_edge_q [$];

   gpif_bridge gpif_bridge_inst (
      .gpif_clk_i     (clk),
      .arst_n_i       (arst_n),
      .gpif_d_i       (gpif_d),
      .gpif_wr_i      (gpif_wr),
      .gpif_rd_i      (gpif_rd),
      .gpif_ep_i      (gpif_ep),
      .gpif_d_o       (gpif_q),
      .gpif_ce_o      (gpif_ce),
      .tx_line_o      (tx_line),
      .tx_valid_o     (tx_valid),
      .resp_overrun_o (resp_overrun)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   always @(posedge clk) cyc <= cyc + 1;

   // Collect transmit lines, tagged with the rising edge that samples the strobe
   always @(negedge clk) begin
      if (arst_n && tx_valid) begin
         tx_q.push_back(tx_line);
         tx_edge_q.push_back(cyc + 1);
      end
   end

   // Assertion failures in the bound checker
   always @(negedge clk) begin
      if (gpif_bridge_inst.gpif_bridge_properties_inst.fail_count != 0) begin
         report_failure("An assertion on the bridge ports failed");
      end
   end

   ////////////////////////////////////////
   // Reporting and compare tasks
   ////////////////////////////////////////

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [`GPIF_WORD_W-1:0] act,
                             input logic [`GPIF_WORD_W-1:0] exp);
      if (act !== exp) begin
         report_failure($sformatf("Error %s: got 0x%h, expected 0x%h", name, act, exp));
      end
   endtask

   task automatic check_line(input string name, input line36_t act, input line36_t exp);
      if (act !== exp) begin
         report_failure($sformatf("Error %s: got 0x%h, expected 0x%h", name, act, exp));
      end
   endtask

   ////////////////////////////////////////
   // Host port drivers
   ////////////////////////////////////////

   // Called on a falling edge, returns on one
   task automatic write_frame(input logic ep);
      for (int i = 0; i < `GPIF_FRAME_WORDS; i++) begin
         gpif_d  = frame_buf[i];
         gpif_ep = ep;
         gpif_wr = 1'b1;
         @(negedge clk);
      end
      last_wr_edge = cyc;
      gpif_wr = 1'b0;
   endtask

   task automatic fill_random();
      for (int i = 0; i < `GPIF_FRAME_WORDS; i++) begin
         frame_buf[i] = $urandom;
      end
   endtask

   // Builds and sends one command, and queues its expected response
   task automatic ctrl_frame(input logic wr, input logic [2:0] seq,
                             input logic [REG_IDX_W-1:0] idx,
                             input logic [`GPIF_WORD_W-1:0] val);
      ctrl_word_u hdr;
      hdr.raw     = '0;
      hdr.hdr.wr  = wr;
      hdr.hdr.seq = seq;
      hdr.hdr.idx = idx;
      if (wr) begin
         exp_regs[idx] = val;
      end
      resp_hdr_q.push_back(hdr.raw);
      resp_val_q.push_back(exp_regs[idx]);
      // Words past the data word carry noise
      fill_random();
      frame_buf[0] = hdr.raw;
      frame_buf[1] = val;
      write_frame(1'b1);
   endtask

   task automatic read_response();
      logic [`GPIF_WORD_W-1:0] exp_hdr;
      logic [`GPIF_WORD_W-1:0] exp_val;
      logic [`GPIF_WORD_W-1:0] exp;
      int                      waited;
      exp_hdr = resp_hdr_q.pop_front();
      exp_val = resp_val_q.pop_front();
      waited  = 0;
      while (gpif_ce !== 1'b0 && waited < WAIT_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (gpif_ce !== 1'b0) begin
         report_failure("No response arrived, the control-empty flag stayed high");
      end
      for (int i = 0; i < `GPIF_FRAME_WORDS; i++) begin
         if (gpif_ce !== 1'b0) begin
            report_failure("Control-empty flag rose before the response was fully read");
         end
         exp = (i == 0) ? exp_hdr : ((i == 1) ? exp_val : '0);
         check_word("gpif_d_o", gpif_q, exp);
         gpif_rd = 1'b1;
         @(negedge clk);
      end
      gpif_rd = 1'b0;
   endtask

   task automatic check_data_frame();
      line36_t exp;
      int      waited;
      int      edge_n;
      waited = 0;
      while (tx_q.size() < HALF_FRAME && waited < WAIT_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (tx_q.size() < HALF_FRAME) begin
         report_failure("Transmit lines missing for the data frame");
      end
      for (int k = 0; k < HALF_FRAME; k++) begin
         exp.sof  = (k == 0);
         exp.eof  = (k == HALF_FRAME - 1);
         exp.occ  = 2'd0;
         exp.data = {frame_buf[2*k+1], frame_buf[2*k]};
         edge_n   = tx_edge_q.pop_front();
         check_line("tx_line_o", tx_q.pop_front(), exp);
      end
      if (edge_n - last_wr_edge != 2) begin
         report_failure($sformatf("Last line came %0d cycles after its write, not 2",
                                  edge_n - last_wr_edge));
      end
   endtask

   ////////////////////////////////////////
   // Directed tests
   ////////////////////////////////////////

   task automatic test_packing();
      fill_random();
      write_frame(1'b0);
      check_data_frame();
   endtask

   task automatic test_reg_access();
      ctrl_frame(1'b1, 3'd1, 4'd3, $urandom);
      read_response();
      ctrl_frame(1'b0, 3'd2, 4'd3, $urandom);
      read_response();
   endtask

   task automatic test_reg_isolation();
      ctrl_frame(1'b1, 3'd3, 4'd5, $urandom);
      read_response();
      ctrl_frame(1'b1, 3'd4, 4'd9, $urandom);
      read_response();
      ctrl_frame(1'b1, 3'd5, 4'd12, $urandom);
      read_response();
      ctrl_frame(1'b0, 3'd6, 4'd12, $urandom);
      read_response();
      ctrl_frame(1'b0, 3'd7, 4'd5, $urandom);
      read_response();
      ctrl_frame(1'b0, 3'd0, 4'd9, $urandom);
      read_response();
      // Never written
      ctrl_frame(1'b0, 3'd1, 4'd7, $urandom);
      read_response();
   endtask

   task automatic test_mixed_endpoints();
      test_packing();
      ctrl_frame(1'b1, 3'd2, 4'd1, $urandom);
      repeat (4) @(negedge clk);
      if (tx_q.size() != 0) begin
         report_failure("Control frame produced transmit lines");
      end
      test_packing();
      read_response();
   endtask

   task automatic test_empty_and_overrun();
      int waited;
      for (int i = 0; i < 3; i++) begin
         gpif_rd = 1'b1;
         @(negedge clk);
         if (gpif_ce !== 1'b1 || resp_overrun !== 1'b0) begin
            report_failure("Read of an empty response buffer changed its flags");
         end
      end
      gpif_rd = 1'b0;
      ctrl_frame(1'b1, 3'd3, 4'd2, $urandom);
      ctrl_frame(1'b0, 3'd4, 4'd9, $urandom);
      ctrl_frame(1'b1, 3'd5, 4'd2, $urandom);
      waited = 0;
      while (resp_overrun !== 1'b1 && waited < WAIT_CYCLES) begin
         @(negedge clk);
         waited++;
      end
      if (resp_overrun !== 1'b1) begin
         report_failure("Response overrun flag did not rise with a full buffer");
      end
      // Let the dropped response finish
      repeat (`GPIF_FRAME_WORDS) @(negedge clk);
      read_response();
      read_response();
      void'(resp_hdr_q.pop_front());
      void'(resp_val_q.pop_front());
      if (gpif_ce !== 1'b1) begin
         report_failure("Words of the dropped response reached the buffer");
      end
   endtask

   ////////////////////////////////////////
   // Sequence and watchdog
   ////////////////////////////////////////

   initial begin
      gpif_d  = '0;
      gpif_wr = 1'b0;
      gpif_rd = 1'b0;
      gpif_ep = 1'b0;
      arst_n  = 1'b1;
      for (int i = 0; i < `GPIF_NUM_REGS; i++) begin
         exp_regs[i] = '0;
      end
      void'($urandom(46));
      // Falling reset edge after time zero so the flops see it
      #(CLK_PERIOD / 4) arst_n = 1'b0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      test_packing();
      test_reg_access();
      test_reg_isolation();
      test_mixed_endpoints();
      test_empty_and_overrun();
      if (gpif_bridge_inst.gpif_bridge_properties_inst.fail_count != 0) begin
         report_failure("An assertion on the bridge ports failed");
      end else begin
         $display("Simulation passed");
         $finish;
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      report_failure("Watchdog expired before the tests finished");
   end

endmodule

`default_nettype wire

/* gpif_bridge.f */
+incdir+hw
hw/gpif_pkg.sv
hw/gpif_wr.sv
hw/line_packer.sv
hw/ctrl_regs.sv
hw/gpif_rd.sv
hw/gpif_bridge.sv
sim/gpif_bridge_properties.sv
sim/gpif_bridge_tb.sv
